//--- common/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width
`define RV_XLEN 32

// Instruction memory depth in words
`define RV_IMEM_WORDS 64

// Data memory depth in words
`define RV_DMEM_WORDS 64

`endif

//--- common/rv_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    typedef logic [ `RV_XLEN - 1 : 0 ] word_t;  // Data or address word

    typedef enum logic [ 6 : 0 ] {
        OPC_OP     = 7'b0110011,  // R-type arithmetic
        OPC_OP_IMM = 7'b0010011,  // I-type arithmetic
        OPC_LOAD   = 7'b0000011,  // lw
        OPC_STORE  = 7'b0100011,  // sw
        OPC_BRANCH = 7'b1100011,  // beq, bne
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [ 3 : 0 ] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B                // Forward b, used by lui
    } alu_ctrl_e;

    typedef enum logic [ 2 : 0 ] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_src_e;

    // Instruction class handed from main to ALU decoder
    typedef enum logic [ 1 : 0 ] {AOP_MEM, AOP_BRANCH, AOP_ARITH, AOP_PASS} alu_op_e;

    typedef struct packed {
        logic [ 6 : 0 ] funct7;
        logic [ 4 : 0 ] rs2;
        logic [ 4 : 0 ] rs1;
        logic [ 2 : 0 ] funct3;
        logic [ 4 : 0 ] rd;
        logic [ 6 : 0 ] opcode;
    } r_t;

    typedef struct packed {
        logic [ 11 : 0 ] imm;     // imm[11:0]
        logic [ 4 : 0 ]  rs1;
        logic [ 2 : 0 ]  funct3;
        logic [ 4 : 0 ]  rd;
        logic [ 6 : 0 ]  opcode;
    } i_t;

    typedef struct packed {
        logic [ 6 : 0 ] imm_hi;   // imm[11:5]
        logic [ 4 : 0 ] rs2;
        logic [ 4 : 0 ] rs1;
        logic [ 2 : 0 ] funct3;
        logic [ 4 : 0 ] imm_lo;   // imm[4:0]
        logic [ 6 : 0 ] opcode;
    } s_t;

    typedef struct packed {
        logic           imm12;
        logic [ 5 : 0 ] imm10_5;
        logic [ 4 : 0 ] rs2;
        logic [ 4 : 0 ] rs1;
        logic [ 2 : 0 ] funct3;
        logic [ 3 : 0 ] imm4_1;
        logic           imm11;
        logic [ 6 : 0 ] opcode;
    } b_t;

    typedef struct packed {
        logic [ 19 : 0 ] imm;     // imm[31:12]
        logic [ 4 : 0 ]  rd;
        logic [ 6 : 0 ]  opcode;
    } u_t;

    typedef struct packed {
        logic           imm20;
        logic [ 9 : 0 ] imm10_1;
        logic           imm11;
        logic [ 7 : 0 ] imm19_12;
        logic [ 4 : 0 ] rd;
        logic [ 6 : 0 ] opcode;
    } j_t;

    // One fetched word, six field layouts
    typedef union packed {
        r_t r;
        i_t i;
        s_t s;
        b_t b;
        u_t u;
        j_t j;
    } instr_u;

endpackage

`default_nettype wire

//--- hw/control/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module instr_mem import rv_pkg::*; (

    input  logic   clk_i,
    input  logic   we_i,      // Load port write enable
    input  word_t  waddr_i,   // Load byte address
    input  word_t  wdata_i,   // Load data
    input  word_t  addr_i,    // Fetch byte address

    output instr_u rd_o       // Fetched instruction

);

localparam int AW = $clog2(`RV_IMEM_WORDS);  // Word index width

word_t mem [ `RV_IMEM_WORDS ];

always_ff @(posedge clk_i) begin
    if (we_i) mem[ waddr_i[ AW + 1 : 2 ] ] <= wdata_i;  // Program load while in reset
end

assign rd_o = mem[ addr_i[ AW + 1 : 2 ] ];  // Async fetch, wraps at depth

endmodule

`default_nettype wire

//--- hw/control/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder import rv_pkg::*; (

    input  opcode_e        op_i,
    input  logic [ 2 : 0 ] funct3_i,       // Branch condition
    input  logic           eq_i,           // Operands equal

    output logic           pc_src_o,       // Take branch or jump
    output logic           jalr_pc_src_o,  // Target from ALU result
    output logic           link_o,         // Write PC + 4 to rd
    output logic           result_src_o,   // Load data to rd
    output logic           mem_write_o,
    output logic           alu_src_o,      // Immediate as ALU b
    output logic           reg_write_o,
    output imm_src_e       imm_src_o,
    output alu_op_e        alu_op_o

);

logic taken;  // Branch condition met

always_comb begin
    case (funct3_i)
        3'b000:  taken = eq_i;   // beq
        3'b001:  taken = ~eq_i;  // bne
        default: taken = 1'b0;
    endcase
end

always_comb begin
    pc_src_o      = 1'b0;      // Sequential by default
    jalr_pc_src_o = 1'b0;
    link_o        = 1'b0;
    result_src_o  = 1'b0;
    mem_write_o   = 1'b0;
    alu_src_o     = 1'b0;
    reg_write_o   = 1'b0;      // Stays low for unknown opcodes
    imm_src_o     = IMM_I;
    alu_op_o      = AOP_MEM;
    case (op_i)
        OPC_OP: begin
            reg_write_o = 1'b1;
            alu_op_o    = AOP_ARITH;
        end
        OPC_OP_IMM: begin
            reg_write_o = 1'b1;
            alu_src_o   = 1'b1;
            alu_op_o    = AOP_ARITH;
        end
        OPC_LOAD: begin
            reg_write_o  = 1'b1;
            alu_src_o    = 1'b1;   // Address = rs1 + imm
            result_src_o = 1'b1;
        end
        OPC_STORE: begin
            mem_write_o = 1'b1;
            alu_src_o   = 1'b1;
            imm_src_o   = IMM_S;
        end
        OPC_BRANCH: begin
            pc_src_o  = taken;
            imm_src_o = IMM_B;
            alu_op_o  = AOP_BRANCH;
        end
        OPC_JAL: begin
            pc_src_o    = 1'b1;
            link_o      = 1'b1;
            reg_write_o = 1'b1;
            imm_src_o   = IMM_J;
        end
        OPC_JALR: begin
            pc_src_o      = 1'b1;
            jalr_pc_src_o = 1'b1;  // Target = rs1 + imm
            link_o        = 1'b1;
            reg_write_o   = 1'b1;
            alu_src_o     = 1'b1;
        end
        OPC_LUI: begin
            reg_write_o = 1'b1;
            alu_src_o   = 1'b1;
            imm_src_o   = IMM_U;
            alu_op_o    = AOP_PASS;
        end
        default: ;
    endcase
end

endmodule

`default_nettype wire

//--- hw/control/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder import rv_pkg::*; (

    input  alu_op_e        alu_op_i,       // Instruction class
    input  logic [ 2 : 0 ] funct3_i,
    input  logic           funct7_i,       // Instruction bit 30
    input  logic           op5_i,          // Set for R-type

    output alu_ctrl_e      alu_control_o

);

always_comb begin
    case (alu_op_i)
        AOP_MEM:    alu_control_o = ALU_ADD;   // Address add, also jalr
        AOP_BRANCH: alu_control_o = ALU_SUB;
        AOP_PASS:   alu_control_o = ALU_PASS_B;
        default: begin
            case (funct3_i)
                3'b000:  alu_control_o = (op5_i & funct7_i) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_control_o = ALU_SLL;
                3'b010:  alu_control_o = ALU_SLT;
                3'b100:  alu_control_o = ALU_XOR;
                3'b101:  alu_control_o = funct7_i ? ALU_SRA : ALU_SRL;
                3'b110:  alu_control_o = ALU_OR;
                3'b111:  alu_control_o = ALU_AND;
                default: alu_control_o = ALU_ADD;  // sltu not supported
            endcase
        end
    endcase
end

endmodule

`default_nettype wire

//--- hw/control/sign_extend.sv
`timescale 1ns/1ps
`default_nettype none

module sign_extend import rv_pkg::*; (

    input  instr_u   instr_i,
    input  imm_src_e imm_src_i,   // Immediate format

    output word_t    imm_ext_o

);

always_comb begin
    case (imm_src_i)
        IMM_S:   imm_ext_o = {{20{instr_i.s.imm_hi[ 6 ]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
        IMM_B:   imm_ext_o = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                              instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};  // Halfword offset
        IMM_U:   imm_ext_o = {instr_i.u.imm, 12'b0};  // Upper 20 bits
        IMM_J:   imm_ext_o = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                              instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
        default: imm_ext_o = {{20{instr_i.i.imm[ 11 ]}}, instr_i.i.imm};  // I-type
    endcase
end

endmodule

`default_nettype wire

//--- hw/control/control_top.sv
`timescale 1ns/1ps
`default_nettype none

module control_top import rv_pkg::*; (

    input  logic           clk_i,
    input  logic           imem_we_i,      // Program load enable
    input  word_t          imem_addr_i,    // Program load byte address
    input  word_t          imem_data_i,    // Program load word
    input  word_t          pc_i,           // Program counter
    input  logic           eq_i,           // ALU operands equal

    output logic           pc_src_o,       // Branch or jump target
    output logic           jalr_pc_src_o,  // Use ALU result as target
    output logic           link_o,         // Write PC + 4 to rd
    output logic           result_src_o,   // Write load data to rd
    output logic           mem_write_o,
    output logic           alu_src_o,      // Immediate on ALU b
    output logic           reg_write_o,
    output alu_ctrl_e      alu_ctrl_o,
    output word_t          imm_op_o,       // Extended immediate
    output logic [ 4 : 0 ] rs1_o,
    output logic [ 4 : 0 ] rs2_o,
    output logic [ 4 : 0 ] rd_o

);

instr_u   instr;     // Word at PC
imm_src_e imm_src;
alu_op_e  alu_op;    // Class code between decoders

assign rs1_o = instr.r.rs1;
assign rs2_o = instr.r.rs2;
assign rd_o  = instr.r.rd;

instr_mem instr_mem (
    .clk_i   (clk_i),
    .we_i    (imem_we_i),
    .waddr_i (imem_addr_i),
    .wdata_i (imem_data_i),
    .addr_i  (pc_i),
    .rd_o    (instr)
);

main_decoder main_decoder (
    .op_i          (opcode_e'(instr.r.opcode)),
    .funct3_i      (instr.r.funct3),
    .eq_i          (eq_i),
    .pc_src_o      (pc_src_o),
    .jalr_pc_src_o (jalr_pc_src_o),
    .link_o        (link_o),
    .result_src_o  (result_src_o),
    .mem_write_o   (mem_write_o),
    .alu_src_o     (alu_src_o),
    .reg_write_o   (reg_write_o),
    .imm_src_o     (imm_src),
    .alu_op_o      (alu_op)
);

alu_decoder alu_decoder (
    .alu_op_i      (alu_op),
    .funct3_i      (instr.r.funct3),
    .funct7_i      (instr.r.funct7[ 5 ]),  // Bit 30, sub and sra
    .op5_i         (instr.r.opcode[ 5 ]),  // R-type vs I-type
    .alu_control_o (alu_ctrl_o)
);

sign_extend sign_extend (
    .instr_i   (instr),
    .imm_src_i (imm_src),
    .imm_ext_o (imm_op_o)
);

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (

    input  word_t     a_i,        // rs1 value
    input  word_t     b_i,        // rs2 value or immediate
    input  alu_ctrl_e ctrl_i,

    output word_t     result_o,
    output logic      eq_o        // Operands equal, for branches

);

assign eq_o = (a_i == b_i);

always_comb begin
    case (ctrl_i)
        ALU_ADD:    result_o = a_i + b_i;
        ALU_SUB:    result_o = a_i - b_i;
        ALU_AND:    result_o = a_i & b_i;
        ALU_OR:     result_o = a_i | b_i;
        ALU_XOR:    result_o = a_i ^ b_i;
        ALU_SLT:    result_o = word_t'($signed(a_i) < $signed(b_i));  // Signed compare
        ALU_SLL:    result_o = a_i << b_i[ 4 : 0 ];
        ALU_SRL:    result_o = a_i >> b_i[ 4 : 0 ];
        ALU_SRA:    result_o = word_t'($signed(a_i) >>> b_i[ 4 : 0 ]);
        ALU_PASS_B: result_o = b_i;
        default:    result_o = '0;
    endcase
end

endmodule

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module datapath import rv_pkg::*; (

    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           pc_src_i,        // Branch or jump taken
    input  logic           jalr_pc_src_i,   // Target from ALU
    input  logic           link_i,          // rd gets PC + 4
    input  logic           result_src_i,    // rd gets load data
    input  logic           mem_write_i,
    input  logic           alu_src_i,       // ALU b from immediate
    input  logic           reg_write_i,
    input  logic [ 4 : 0 ] rs1_i,
    input  logic [ 4 : 0 ] rs2_i,
    input  logic [ 4 : 0 ] rd_i,
    input  word_t          imm_i,
    input  word_t          alu_result_i,

    output word_t          pc_o,            // Fetch address
    output word_t          alu_a_o,
    output word_t          alu_b_o,
    output logic           retire_valid_o,
    output word_t          retire_pc_o,
    output logic           reg_write_o,
    output logic [ 4 : 0 ] rd_o,
    output word_t          rd_data_o,
    output logic           mem_write_o,
    output word_t          mem_addr_o,
    output word_t          mem_wdata_o

);

localparam int DW = $clog2(`RV_DMEM_WORDS);  // Data word index width

word_t pc;
word_t pc_plus4;
word_t pc_next;
word_t rs1_data;
word_t rs2_data;
word_t result;                               // Write-back value
logic  rf_we;
logic  dm_we;
word_t regs [ 32 ];
word_t dmem [ `RV_DMEM_WORDS ];

initial begin                                // Memories power up cleared
    for (int i = 0; i < 32; i++) regs[ i ] = '0;
    for (int i = 0; i < `RV_DMEM_WORDS; i++) dmem[ i ] = '0;
end

assign pc_plus4 = pc + 32'd4;
assign pc_next  = !pc_src_i     ? pc_plus4 :
                  jalr_pc_src_i ? {alu_result_i[ 31 : 1 ], 1'b0} :  // jalr clears bit 0
                                  pc + imm_i;                     // Branch or jal

always_ff @(posedge clk_i) begin
    if (reset_i) pc <= '0;
    else         pc <= pc_next;
end

// No state change while in reset
assign rf_we = reg_write_i & ~reset_i;
assign dm_we = mem_write_i & ~reset_i;

assign rs1_data = (rs1_i == 5'd0) ? '0 : regs[ rs1_i ];  // x0 hardwired
assign rs2_data = (rs2_i == 5'd0) ? '0 : regs[ rs2_i ];

always_ff @(posedge clk_i) begin
    if (rf_we && rd_i != 5'd0) regs[ rd_i ] <= result;  // Writes to x0 dropped
    if (dm_we) dmem[ alu_result_i[ DW + 1 : 2 ] ] <= rs2_data;
end

assign result = link_i       ? pc_plus4 :
                result_src_i ? dmem[ alu_result_i[ DW + 1 : 2 ] ] : alu_result_i;

assign pc_o    = pc;
assign alu_a_o = rs1_data;
assign alu_b_o = alu_src_i ? imm_i : rs2_data;

// Retire trace for the instruction at the PC
assign retire_valid_o = ~reset_i;
assign retire_pc_o    = pc;
assign reg_write_o    = rf_we;
assign rd_o           = rd_i;
assign rd_data_o      = result;
assign mem_write_o    = dm_we;
assign mem_addr_o     = alu_result_i;
assign mem_wdata_o    = rs2_data;

endmodule

`default_nettype wire

//--- hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (

    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           imem_we_i,       // Program load, only in reset
    input  word_t          imem_addr_i,
    input  word_t          imem_data_i,

    output logic           retire_valid_o,
    output word_t          retire_pc_o,
    output logic           reg_write_o,
    output logic [ 4 : 0 ] rd_o,
    output word_t          rd_data_o,
    output logic           mem_write_o,
    output word_t          mem_addr_o,
    output word_t          mem_wdata_o

);

logic           pc_src, jalr_pc_src, link, result_src;
logic           mem_write, alu_src, reg_write;
logic           alu_eq;
logic [ 4 : 0 ] rs1, rs2, rd;
alu_ctrl_e      alu_ctrl;
word_t          imm_op, pc, alu_a, alu_b, alu_result;

control_top control_top (
    .clk_i         (clk_i),
    .imem_we_i     (imem_we_i),
    .imem_addr_i   (imem_addr_i),
    .imem_data_i   (imem_data_i),
    .pc_i          (pc),
    .eq_i          (alu_eq),
    .pc_src_o      (pc_src),
    .jalr_pc_src_o (jalr_pc_src),
    .link_o        (link),
    .result_src_o  (result_src),
    .mem_write_o   (mem_write),
    .alu_src_o     (alu_src),
    .reg_write_o   (reg_write),
    .alu_ctrl_o    (alu_ctrl),
    .imm_op_o      (imm_op),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd)
);

datapath datapath (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .pc_src_i       (pc_src),
    .jalr_pc_src_i  (jalr_pc_src),
    .link_i         (link),
    .result_src_i   (result_src),
    .mem_write_i    (mem_write),
    .alu_src_i      (alu_src),
    .reg_write_i    (reg_write),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .rd_i           (rd),
    .imm_i          (imm_op),
    .alu_result_i   (alu_result),
    .pc_o           (pc),
    .alu_a_o        (alu_a),
    .alu_b_o        (alu_b),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .reg_write_o    (reg_write_o),
    .rd_o           (rd_o),
    .rd_data_o      (rd_data_o),
    .mem_write_o    (mem_write_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o)
);

alu alu (
    .a_i      (alu_a),
    .b_i      (alu_b),
    .ctrl_i   (alu_ctrl),
    .result_o (alu_result),
    .eq_o     (alu_eq)      // Back to the branch decision
);

endmodule

`default_nettype wire

//--- verif/rv_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties import rv_pkg::*; (

    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  retire_valid_i,
    input  word_t retire_pc_i,
    input  logic  reg_write_i,
    input  logic  mem_write_i

);

int fail_count = 0;  // Read by the testbench at the end

a_pc_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    retire_pc_i[ 1 : 0 ] == 2'b00)
    else begin
        fail_count++;
        $error("retire_pc_o is not word aligned");
    end

a_one_write: assert property (@(posedge clk_i) disable iff (reset_i)
    !(reg_write_i && mem_write_i))  // A single instruction writes one place
    else begin
        fail_count++;
        $error("reg_write_o and mem_write_o high together");
    end

a_quiet_in_reset: assert property (@(posedge clk_i)
    reset_i |-> (!retire_valid_i && !reg_write_i && !mem_write_i))
    else begin
        fail_count++;
        $error("Trace active while reset_i is high");
    end

endmodule

`default_nettype wire

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_core_tb import rv_pkg::*; ();

localparam int    PROG_WORDS  = 48;
localparam int    MAX_RETIRES = 200;                      // Cycle limit for the run
localparam word_t FINAL_PC    = (PROG_WORDS - 1) * 4;     // Self-loop jal

logic           clk;
logic           reset;
logic           imem_we;
word_t          imem_addr;
word_t          imem_data;
logic           retire_valid;
word_t          retire_pc;
logic           reg_write;
logic [ 4 : 0 ] rd;
word_t          rd_data;
logic           mem_write;
word_t          mem_addr;
word_t          mem_wdata;

integer         seed;
int             errors;
int             retires;
word_t          prog [ PROG_WORDS ];                      // Program image
word_t          m_regs [ 32 ];                            // Reference model state
word_t          m_mem [ `RV_DMEM_WORDS ];
word_t          m_pc;
logic           exp_rwe;                                  // Expected trace of one step
logic [ 4 : 0 ] exp_rd;
word_t          exp_data;
logic           exp_mwe;
word_t          exp_maddr;
word_t          exp_mdata;
logic [ 2 : 0 ] imm_f3 [ 5 ] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};  // addi..andi

always #10 clk = ~clk;

rv_core i_dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .imem_we_i      (imem_we),
    .imem_addr_i    (imem_addr),
    .imem_data_i    (imem_data),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .reg_write_o    (reg_write),
    .rd_o           (rd),
    .rd_data_o      (rd_data),
    .mem_write_o    (mem_write),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata)
);

bind rv_core rv_core_properties i_props (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .retire_valid_i (retire_valid_o),
    .retire_pc_i    (retire_pc_o),
    .reg_write_i    (reg_write_o),
    .mem_write_i    (mem_write_o)
);

function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
endfunction

// Instruction encoders, one per format
function automatic word_t enc_r(input logic [ 6 : 0 ] f7, input logic [ 4 : 0 ] rs2,
                                input logic [ 4 : 0 ] rs1, input logic [ 2 : 0 ] f3,
                                input logic [ 4 : 0 ] rd_f);
    return {f7, rs2, rs1, f3, rd_f, 7'b0110011};
endfunction

function automatic word_t enc_i(input logic [ 11 : 0 ] imm, input logic [ 4 : 0 ] rs1,
                                input logic [ 2 : 0 ] f3, input logic [ 4 : 0 ] rd_f,
                                input logic [ 6 : 0 ] op);
    return {imm, rs1, f3, rd_f, op};
endfunction

function automatic word_t enc_s(input logic [ 11 : 0 ] imm, input logic [ 4 : 0 ] rs2,
                                input logic [ 4 : 0 ] rs1);
    return {imm[ 11 : 5 ], rs2, rs1, 3'b010, imm[ 4 : 0 ], 7'b0100011};
endfunction

function automatic word_t enc_b(input logic [ 12 : 0 ] imm, input logic [ 4 : 0 ] rs2,
                                input logic [ 4 : 0 ] rs1, input logic [ 2 : 0 ] f3);
    return {imm[ 12 ], imm[ 10 : 5 ], rs2, rs1, f3, imm[ 4 : 1 ], imm[ 11 ], 7'b1100011};
endfunction

function automatic word_t enc_u(input logic [ 19 : 0 ] imm, input logic [ 4 : 0 ] rd_f);
    return {imm, rd_f, 7'b0110111};
endfunction

function automatic word_t enc_j(input logic [ 20 : 0 ] imm, input logic [ 4 : 0 ] rd_f);
    return {imm[ 20 ], imm[ 10 : 1 ], imm[ 11 ], imm[ 19 : 12 ], rd_f, 7'b1101111};
endfunction

task automatic build_program();
    int             i;
    int             k;
    int             t;
    int             span;
    logic [ 4 : 0 ] r_d;
    logic [ 4 : 0 ] rs1;
    logic [ 4 : 0 ] rs2;
    logic [ 2 : 0 ] f3;
    logic [ 6 : 0 ] f7;
    bit             tgt [ PROG_WORDS ];                  // Words a jump or branch lands on
    for (int w = 0; w < PROG_WORDS; w++) tgt[ w ] = 1'b0;
    i = 0;
    while (i < PROG_WORDS - 1) begin
        r_d = 5'(rnd(10));                               // Small register set, x0 included
        rs1 = 5'(rnd(10));
        rs2 = 5'(rnd(10));
        k   = rnd(10);
        if (k == 9 && (i > PROG_WORDS - 5 || tgt[ i + 1 ] || tgt[ i + 2 ]))
            k = 2;                                       // No room, or a jump lands inside
        case (k)
            0, 1: begin
                f3 = 3'(rnd(8));
                if (f3 == 3'b011) f3 = 3'b010;           // sltu left out
                f7 = 7'h00;
                if ((f3 == 3'b000 || f3 == 3'b101) && rnd(2) == 1) f7 = 7'h20;  // sub, sra
                prog[ i ] = enc_r(f7, rs2, rs1, f3, r_d);
            end
            2, 3: prog[ i ] = enc_i(12'(rnd(4096)), rs1, imm_f3[ rnd(5) ], r_d, 7'b0010011);
            4: prog[ i ] = enc_u(20'(rnd(1 << 20)), r_d);
            5: prog[ i ] = enc_i(12'(rnd(16) * 4), 5'd0, 3'b010, r_d, 7'b0000011);  // lw
            6: prog[ i ] = enc_s(12'(rnd(16) * 4), rs2, 5'd0);                      // sw
            7, 8: begin
                span = PROG_WORDS - 1 - i;
                if (span > 4) span = 4;
                t = i + 1 + rnd(span);                   // Forward target in program
                tgt[ t ] = 1'b1;
                if (k == 8) begin
                    prog[ i ] = enc_j(21'((t - i) * 4), r_d);
                end else begin
                    rs1 = 5'(rnd(4));                    // Few registers, more equal pairs
                    rs2 = 5'(rnd(4));
                    f3  = rnd(2) ? 3'b001 : 3'b000;
                    prog[ i ] = enc_b(13'((t - i) * 4), rs2, rs1, f3);
                end
            end
            default: begin                               // lui, addi, jalr group
                rs1  = 5'(1 + rnd(9));
                span = PROG_WORDS - 3 - i;
                if (span > 3) span = 3;
                t = i + 3 + rnd(span);
                tgt[ t ] = 1'b1;
                prog[ i ]     = enc_u(20'd0, rs1);
                prog[ i + 1 ] = enc_i(12'(t * 4 + 1), rs1, 3'b000, rs1, 7'b0010011);  // Odd
                prog[ i + 2 ] = enc_i(12'd0, rs1, 3'b000, r_d, 7'b1100111);
                i += 2;
            end
        endcase
        i++;
    end
    prog[ PROG_WORDS - 1 ] = enc_j(21'd0, 5'd0);         // jal x0, 0
endtask

function automatic word_t alu_ref(input logic [ 2 : 0 ] f3, input logic alt,
                                  input word_t a, input word_t b);
    word_t sra_val;
    sra_val = $signed(a) >>> b[ 4 : 0 ];
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[ 4 : 0 ];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? sra_val : a >> b[ 4 : 0 ];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// ISA step of the reference model, fills the expected trace and commits
task automatic model_step();
    word_t instr;
    word_t a;
    word_t b;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;
    word_t addr;
    word_t next_pc;
    instr     = prog[ m_pc >> 2 ];
    a         = m_regs[ instr[ 19 : 15 ] ];
    b         = m_regs[ instr[ 24 : 20 ] ];
    imm_i     = {{20{instr[ 31 ]}}, instr[ 31 : 20 ]};
    imm_s     = {{20{instr[ 31 ]}}, instr[ 31 : 25 ], instr[ 11 : 7 ]};
    imm_b     = {{20{instr[ 31 ]}}, instr[ 7 ], instr[ 30 : 25 ], instr[ 11 : 8 ], 1'b0};
    imm_j     = {{12{instr[ 31 ]}}, instr[ 19 : 12 ], instr[ 20 ], instr[ 30 : 21 ], 1'b0};
    exp_rwe   = 1'b0;
    exp_rd    = instr[ 11 : 7 ];
    exp_data  = '0;
    exp_mwe   = 1'b0;
    exp_maddr = '0;
    exp_mdata = '0;
    next_pc   = m_pc + 4;
    case (instr[ 6 : 0 ])
        7'b0110011: begin
            exp_rwe  = 1'b1;
            exp_data = alu_ref(instr[ 14 : 12 ], instr[ 30 ], a, b);
        end
        7'b0010011: begin
            exp_rwe  = 1'b1;
            exp_data = alu_ref(instr[ 14 : 12 ], 1'b0, a, imm_i);  // No subi
        end
        7'b0000011: begin
            addr     = a + imm_i;
            exp_rwe  = 1'b1;
            exp_data = m_mem[ (addr >> 2) % `RV_DMEM_WORDS ];
        end
        7'b0100011: begin
            exp_mwe   = 1'b1;
            exp_maddr = a + imm_s;
            exp_mdata = b;
        end
        7'b1100011: if ((a == b) != instr[ 12 ]) next_pc = m_pc + imm_b;  // beq, bne
        7'b1101111: begin
            exp_rwe  = 1'b1;
            exp_data = m_pc + 4;
            next_pc  = m_pc + imm_j;
        end
        7'b1100111: begin
            exp_rwe  = 1'b1;
            exp_data = m_pc + 4;
            next_pc  = (a + imm_i) & ~32'd1;
        end
        7'b0110111: begin
            exp_rwe  = 1'b1;
            exp_data = {instr[ 31 : 12 ], 12'b0};
        end
        default: ;
    endcase
    if (exp_rwe && exp_rd != 5'd0) m_regs[ exp_rd ] = exp_data;  // x0 stays zero
    if (exp_mwe) m_mem[ (exp_maddr >> 2) % `RV_DMEM_WORDS ] = exp_mdata;
    m_pc = next_pc;
endtask

task automatic check_pc(input word_t got, input word_t exp);
    if (got !== exp) begin
        errors++;
        $display("[FAIL] retire_pc_o got %h expected %h", got, exp);
    end
endtask

task automatic check_reg_write(input logic got_we, input logic exp_we,
                               input logic [ 4 : 0 ] got_rd, input logic [ 4 : 0 ] exp_rd_v,
                               input word_t got_data, input word_t exp_data_v);
    if (got_we !== exp_we) begin
        errors++;
        $display("[FAIL] reg_write_o got %h expected %h", got_we, exp_we);
    end else if (exp_we) begin
        if (got_rd !== exp_rd_v) begin
            errors++;
            $display("[FAIL] rd_o got %h expected %h", got_rd, exp_rd_v);
        end
        if (got_data !== exp_data_v) begin
            errors++;
            $display("[FAIL] rd_data_o got %h expected %h", got_data, exp_data_v);
        end
    end
endtask

task automatic check_mem_write(input logic got_we, input logic exp_we,
                               input word_t got_addr, input word_t exp_addr,
                               input word_t got_data, input word_t exp_data_v);
    if (got_we !== exp_we) begin
        errors++;
        $display("[FAIL] mem_write_o got %h expected %h", got_we, exp_we);
    end else if (exp_we) begin
        if (got_addr !== exp_addr) begin
            errors++;
            $display("[FAIL] mem_addr_o got %h expected %h", got_addr, exp_addr);
        end
        if (got_data !== exp_data_v) begin
            errors++;
            $display("[FAIL] mem_wdata_o got %h expected %h", got_data, exp_data_v);
        end
    end
endtask

initial begin
    int cycles;
    int prop_fails;
    bit done;
    bit timed_out;
    seed      = 32'hf28287a6;
    errors    = 0;
    retires   = 0;
    cycles    = 0;
    done      = 1'b0;
    timed_out = 1'b0;
    clk       = 1'b0;
    reset     = 1'b1;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    m_pc      = '0;
    for (int r = 0; r < 32; r++) m_regs[ r ] = '0;
    for (int w = 0; w < `RV_DMEM_WORDS; w++) m_mem[ w ] = '0;  // Unwritten words read zero
    build_program();
    for (int w = 0; w < PROG_WORDS; w++) begin                 // Load while in reset
        @(posedge clk);
        #1;
        imem_we   = 1'b1;
        imem_addr = w * 4;
        imem_data = prog[ w ];
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
    repeat (4) @(posedge clk);                                 // Reset cycles after the load
    #1;
    reset = 1'b0;
    while (!done && cycles < MAX_RETIRES) begin
        @(negedge clk);                                        // Trace is stable mid-cycle
        cycles++;
        if (!retire_valid) begin
            errors++;
            $display("[FAIL] retire_valid_o got %h expected %h", retire_valid, 1'b1);
        end else begin
            check_pc(retire_pc, m_pc);
            if (m_pc == FINAL_PC) begin
                done = 1'b1;
            end else begin
                model_step();
                check_reg_write(reg_write, exp_rwe, rd, exp_rd, rd_data, exp_data);
                check_mem_write(mem_write, exp_mwe, mem_addr, exp_maddr, mem_wdata, exp_mdata);
                retires++;
            end
        end
    end
    if (!done) begin
        timed_out = 1'b1;
        $display("Timeout: the final self-loop was not reached within %0d retires", MAX_RETIRES);
    end
    prop_fails = i_dut.i_props.fail_count;
    $display("Retired %0d, check errors %0d, assertion failures %0d, timeouts %0d",
             retires, errors, prop_fails, timed_out);
    if (errors == 0 && prop_fails == 0 && !timed_out) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/rv_pkg.sv
hw/control/instr_mem.sv
hw/control/main_decoder.sv
hw/control/alu_decoder.sv
hw/control/sign_extend.sv
hw/control/control_top.sv
hw/alu.sv
hw/datapath.sv
hw/rv_core.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv
